//--- design/cpu_settings.svh
// -------------------------------------------------------------------------
// CPU core settings
// Widths, opcodes, ALU op codes and fixed register numbers
// -------------------------------------------------------------------------
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Datapath
`define WORD_BITS      32   // Data and address width
`define REG_ADDR_BITS  5    // Register number width

// Opcodes, bits 31:27 of every instruction
`define OPC_RTYPE  5'b00000
`define OPC_J      5'b00001
`define OPC_BNE    5'b00010
`define OPC_JAL    5'b00011
`define OPC_JR     5'b00100
`define OPC_ADDI   5'b00101
`define OPC_BLT    5'b00110
`define OPC_SW     5'b00111
`define OPC_LW     5'b01000

// ALU op codes, R-type aluop field
`define ALU_ADD  5'b00000
`define ALU_SUB  5'b00001
`define ALU_AND  5'b00010
`define ALU_OR   5'b00011
`define ALU_SLL  5'b00100
`define ALU_SRA  5'b00101

// Link register for jal
`define LINK_REG  5'd31

`endif

//--- design/cpu_pkg.sv
// -------------------------------------------------------------------------
// CPU core package
// Instruction word type with its R, I and J views
// -------------------------------------------------------------------------
`default_nettype none

`include "cpu_settings.svh"

package cpu_pkg;

    // One 32-bit word, three decodes of the same bits
    typedef union packed {
        struct packed {
            logic [4:0]                opcode;
            logic [`REG_ADDR_BITS-1:0] rd;      // Destination
            logic [`REG_ADDR_BITS-1:0] rs;      // Source A
            logic [`REG_ADDR_BITS-1:0] rt;      // Source B
            logic [4:0]                shamt;
            logic [4:0]                aluop;
            logic [1:0]                unused;
        } r;
        struct packed {
            logic [4:0]                opcode;
            logic [`REG_ADDR_BITS-1:0] rd;      // Dest, or store/branch operand
            logic [`REG_ADDR_BITS-1:0] rs;      // Base or compare operand
            logic [16:0]               immediate; // Signed
        } i;
        struct packed {
            logic [4:0]  opcode;
            logic [26:0] target;                // Absolute word address
        } j;
    } instr_t;

endpackage

`default_nettype wire

//--- design/alu.sv
// -------------------------------------------------------------------------
// ALU with add, sub, and, or, sll, sra and compare flags
// -------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module alu (
    input  logic [`WORD_BITS-1:0] a,
    input  logic [`WORD_BITS-1:0] b,
    input  logic [4:0]            op,
    input  logic [4:0]            shamt,      // Shifts move A only
    output logic [`WORD_BITS-1:0] result,
    output logic                  neq,        // A != B
    output logic                  lt          // Signed A < B
);

    always_comb begin
        case (op)
            `ALU_ADD: result = a + b;
            `ALU_SUB: result = a - b;
            `ALU_AND: result = a & b;
            `ALU_OR:  result = a | b;
            `ALU_SLL: result = a << shamt;
            `ALU_SRA: result = $signed(a) >>> shamt;
            default:  result = '0;
        endcase
    end

    // Flags ignore op
    assign neq = (a != b);
    assign lt  = ($signed(a) < $signed(b));

endmodule

`default_nettype wire

//--- design/reg_file.sv
// -------------------------------------------------------------------------
// Register file, 32 by 32 bits
// Two combinational reads with write bypass, r0 fixed at zero
// -------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module reg_file (
    input  logic                      clock,
    input  logic                      rst,
    input  logic                      we,
    input  logic [`REG_ADDR_BITS-1:0] wr_reg,
    input  logic [`WORD_BITS-1:0]     wr_data,
    input  logic [`REG_ADDR_BITS-1:0] rd_a_reg,
    input  logic [`REG_ADDR_BITS-1:0] rd_b_reg,
    output logic [`WORD_BITS-1:0]     rd_a,
    output logic [`WORD_BITS-1:0]     rd_b
);

    logic [`WORD_BITS-1:0] regs [2**`REG_ADDR_BITS];

    // Same-cycle write shows through
    function automatic logic [`WORD_BITS-1:0] read_port(
        input logic [`REG_ADDR_BITS-1:0] sel
    );
        if (sel == '0)
            return '0;
        if (we && (sel == wr_reg))
            return wr_data;
        return regs[sel];
    endfunction

    assign rd_a = read_port(rd_a_reg);
    assign rd_b = read_port(rd_b_reg);

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < 2**`REG_ADDR_BITS; i++)
                regs[i] <= '0;
        end else if (we && (wr_reg != '0)) begin
            regs[wr_reg] <= wr_data;
        end
    end

endmodule

`default_nettype wire

//--- design/fetch_unit.sv
// -------------------------------------------------------------------------
// Fetch stage
// PC register, next-PC select and the FD pipeline register
// -------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module fetch_unit import cpu_pkg::*; (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  stall,         // Hold PC and FD
    input  logic                  take_jump,     // Redirect from execute
    input  logic [`WORD_BITS-1:0] jump_pc,
    output logic [`WORD_BITS-1:0] address_imem,
    input  logic [`WORD_BITS-1:0] q_imem,
    output logic [`WORD_BITS-1:0] fd_pc,         // PC+1 of the FD instruction
    output instr_t                fd_instr
);

    logic [`WORD_BITS-1:0] pc;
    logic [`WORD_BITS-1:0] pc_plus1;

    assign pc_plus1     = pc + 1'b1;
    assign address_imem = pc;

    // Jump beats stall; the two never coincide anyway
    always_ff @(posedge clock) begin
        if (rst) begin
            pc       <= '0;
            fd_pc    <= '0;
            fd_instr <= '0;
        end else if (take_jump) begin
            pc       <= jump_pc;
            fd_pc    <= pc_plus1;
            fd_instr <= '0;              // Squash the wrong-path fetch
        end else if (!stall) begin
            pc       <= pc_plus1;
            fd_pc    <= pc_plus1;
            fd_instr <= q_imem;
        end
    end

endmodule

`default_nettype wire

//--- design/decode_unit.sv
// -------------------------------------------------------------------------
// Decode stage
// Register read select, load-use stall and the DX pipeline register
// -------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module decode_unit import cpu_pkg::*; (
    input  logic                      clock,
    input  logic                      rst,
    input  logic [`WORD_BITS-1:0]     fd_pc,
    input  instr_t                    fd_instr,
    input  logic                      take_jump,
    input  logic                      is_jal,
    output logic [`REG_ADDR_BITS-1:0] rd_a_reg,   // Regfile port A select
    output logic [`REG_ADDR_BITS-1:0] rd_b_reg,   // Regfile port B select
    input  logic [`WORD_BITS-1:0]     rd_a,
    input  logic [`WORD_BITS-1:0]     rd_b,
    output logic                      stall,
    output logic [`WORD_BITS-1:0]     dx_pc,
    output logic [`WORD_BITS-1:0]     dx_a,
    output logic [`WORD_BITS-1:0]     dx_b,
    output instr_t                    dx_instr
);

    logic   link;                         // jal taken this cycle
    instr_t link_instr;                   // add r31 with A overridden

    // Unused ports read r0, so they never match a load below
    always_comb begin
        rd_a_reg = fd_instr.r.rs;
        rd_b_reg = '0;
        case (fd_instr.r.opcode)
            `OPC_RTYPE:                     rd_b_reg = fd_instr.r.rt;
            `OPC_SW, `OPC_BNE, `OPC_BLT:    rd_b_reg = fd_instr.i.rd;
            `OPC_JR:                        rd_a_reg = fd_instr.i.rd;
            `OPC_ADDI, `OPC_LW:             rd_b_reg = '0;
            default:                        rd_a_reg = '0;   // j, jal, nop
        endcase
    end

    // Load result not ready until MW
    assign stall = (dx_instr.i.opcode == `OPC_LW) && (dx_instr.i.rd != '0) &&
                   ((dx_instr.i.rd == rd_a_reg) || (dx_instr.i.rd == rd_b_reg));

    assign link = take_jump && is_jal;

    always_comb begin
        link_instr         = '0;
        link_instr.r.opcode = `OPC_RTYPE;
        link_instr.r.rd    = `LINK_REG;
        link_instr.r.aluop = `ALU_ADD;
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            dx_pc    <= '0;
            dx_a     <= '0;
            dx_b     <= '0;
            dx_instr <= '0;
        end else begin
            dx_pc    <= fd_pc;
            dx_a     <= link ? dx_pc : rd_a;   // dx_pc is the jal's own PC+1
            dx_b     <= link ? '0 : rd_b;
            if (link)
                dx_instr <= link_instr;
            else if (stall || take_jump)
                dx_instr <= '0;               // Bubble
            else
                dx_instr <= fd_instr;
        end
    end

endmodule

`default_nettype wire

//--- design/execute_unit.sv
// -------------------------------------------------------------------------
// Execute stage
// Operand bypass, ALU, branch and jump resolution, XM pipeline register
// -------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module execute_unit import cpu_pkg::*; (
    input  logic                      clock,
    input  logic                      rst,
    input  logic [`WORD_BITS-1:0]     dx_pc,       // PC+1
    input  logic [`WORD_BITS-1:0]     dx_a,
    input  logic [`WORD_BITS-1:0]     dx_b,
    input  instr_t                    dx_instr,
    input  logic [`WORD_BITS-1:0]     wb_value,    // Writeback bypass
    input  logic [`REG_ADDR_BITS-1:0] wb_reg,
    input  logic                      wb_en,
    output logic                      take_jump,
    output logic [`WORD_BITS-1:0]     jump_pc,
    output logic                      is_jal,
    output logic [`WORD_BITS-1:0]     xm_value,
    output logic [`WORD_BITS-1:0]     xm_b,        // Store data
    output instr_t                    xm_instr
);

    logic [4:0]                opcode;
    logic [`WORD_BITS-1:0]     imm;
    logic [`REG_ADDR_BITS-1:0] src_a, src_b;
    logic                      xm_writes;          // XM result bound for regfile
    logic [`WORD_BITS-1:0]     op_a, op_b, alu_b, alu_result;
    logic [4:0]                alu_op;
    logic                      neq, lt, use_imm, branch_taken;

    // Newest producer first, r0 never bypassed
    function automatic logic [`WORD_BITS-1:0] bypass(
        input logic [`REG_ADDR_BITS-1:0] src,
        input logic [`WORD_BITS-1:0]     reg_val
    );
        if (src != '0 && xm_writes && (src == xm_instr.r.rd))
            return xm_value;
        if (src != '0 && wb_en && (src == wb_reg))
            return wb_value;
        return reg_val;
    endfunction

    assign opcode = dx_instr.r.opcode;
    assign imm    = {{(`WORD_BITS-17){dx_instr.i.immediate[16]}}, dx_instr.i.immediate};

    // Same source choice as decode
    assign src_a = (opcode == `OPC_JR) ? dx_instr.i.rd : dx_instr.r.rs;
    assign src_b = (opcode == `OPC_RTYPE) ? dx_instr.r.rt : dx_instr.i.rd;

    // Loads in XM hold an address, the stall covers them
    assign xm_writes = (xm_instr.r.opcode == `OPC_RTYPE) ||
                       (xm_instr.r.opcode == `OPC_ADDI);

    assign op_a    = bypass(src_a, dx_a);
    assign op_b    = bypass(src_b, dx_b);
    assign use_imm = (opcode == `OPC_ADDI) || (opcode == `OPC_LW) || (opcode == `OPC_SW);
    assign alu_b   = use_imm ? imm : op_b;
    assign alu_op  = (opcode == `OPC_RTYPE) ? dx_instr.r.aluop : `ALU_ADD;

    alu alu_i (
        .a      (op_a),
        .b      (alu_b),
        .op     (alu_op),
        .shamt  (dx_instr.r.shamt),
        .result (alu_result),
        .neq,
        .lt
    );

    // A is rs, B is rd; blt wants rd < rs
    assign branch_taken = ((opcode == `OPC_BNE) && neq) ||
                          ((opcode == `OPC_BLT) && neq && !lt);

    assign is_jal    = (opcode == `OPC_JAL);
    assign take_jump = branch_taken || is_jal || (opcode == `OPC_J) ||
                       (opcode == `OPC_JR);

    always_comb begin
        case (opcode)
            `OPC_J, `OPC_JAL: jump_pc = {{(`WORD_BITS-27){1'b0}}, dx_instr.j.target};
            `OPC_JR:          jump_pc = op_a;
            default:          jump_pc = dx_pc + imm;   // PC+1+imm
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            xm_value <= '0;
            xm_b     <= '0;
            xm_instr <= '0;
        end else begin
            xm_value <= alu_result;
            xm_b     <= op_b;
            xm_instr <= (take_jump && !is_jal) ? '0 : dx_instr;
        end
    end

endmodule

`default_nettype wire

//--- design/memory_writeback.sv
// -------------------------------------------------------------------------
// Memory and writeback stages
// Store control, MW pipeline register and the regfile write port
// -------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module memory_writeback import cpu_pkg::*; (
    input  logic                      clock,
    input  logic                      rst,
    input  logic [`WORD_BITS-1:0]     xm_value,     // ALU result or address
    input  logic [`WORD_BITS-1:0]     xm_b,
    input  instr_t                    xm_instr,
    output logic [`WORD_BITS-1:0]     address_dmem,
    output logic [`WORD_BITS-1:0]     data,
    output logic                      wren,
    input  logic [`WORD_BITS-1:0]     q_dmem,
    output logic                      wb_en,
    output logic [`REG_ADDR_BITS-1:0] wb_reg,
    output logic [`WORD_BITS-1:0]     wb_value
);

    logic [`WORD_BITS-1:0] mw_value;
    logic [`WORD_BITS-1:0] mw_mem;              // Load data
    instr_t                mw_instr;
    logic                  mw_is_lw;

    // ---------------------------------------------------------------------
    // Memory stage
    // ---------------------------------------------------------------------
    assign address_dmem = xm_value;
    assign wren         = (xm_instr.i.opcode == `OPC_SW);
    // wb_en is never set for r0
    assign data = (wb_en && (wb_reg == xm_instr.i.rd)) ? wb_value : xm_b;

    always_ff @(posedge clock) begin
        if (rst) begin
            mw_value <= '0;
            mw_mem   <= '0;
            mw_instr <= '0;
        end else begin
            mw_value <= xm_value;
            mw_mem   <= q_dmem;
            mw_instr <= xm_instr;
        end
    end

    // ---------------------------------------------------------------------
    // Writeback stage
    // ---------------------------------------------------------------------
    assign mw_is_lw = (mw_instr.i.opcode == `OPC_LW);
    assign wb_reg   = mw_instr.i.rd;
    assign wb_value = mw_is_lw ? mw_mem : mw_value;
    assign wb_en    = (wb_reg != '0) &&
                      (mw_is_lw || (mw_instr.i.opcode == `OPC_RTYPE) ||
                       (mw_instr.i.opcode == `OPC_ADDI));

endmodule

`default_nettype wire

//--- design/processor.sv
// -------------------------------------------------------------------------
// Five-stage pipelined CPU core
// Fetch, decode, execute, memory and writeback with an internal regfile
// -------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module processor import cpu_pkg::*; (
    input  logic                  clock,         // Master clock
    input  logic                  rst,           // Sync reset, active high
    // Instruction memory, combinational read
    output logic [`WORD_BITS-1:0] address_imem,
    input  logic [`WORD_BITS-1:0] q_imem,
    // Data memory, combinational read, write on rising edge
    output logic [`WORD_BITS-1:0] address_dmem,
    output logic [`WORD_BITS-1:0] data,          // Store data
    output logic                  wren,          // One strobe per store
    input  logic [`WORD_BITS-1:0] q_dmem
);

    // FD stage
    logic [`WORD_BITS-1:0]     fd_pc;
    instr_t                    fd_instr;
    // DX stage and register reads
    logic [`WORD_BITS-1:0]     dx_pc, dx_a, dx_b;
    instr_t                    dx_instr;
    logic [`REG_ADDR_BITS-1:0] rd_a_reg, rd_b_reg;
    logic [`WORD_BITS-1:0]     rd_a, rd_b;
    logic                      stall;            // Load-use hazard
    // Execute control back to the front end
    logic                      take_jump, is_jal;
    logic [`WORD_BITS-1:0]     jump_pc;
    // XM stage
    logic [`WORD_BITS-1:0]     xm_value, xm_b;
    instr_t                    xm_instr;
    // Writeback
    logic                      wb_en;
    logic [`REG_ADDR_BITS-1:0] wb_reg;
    logic [`WORD_BITS-1:0]     wb_value;

    fetch_unit fetch_i (
        .clock, .rst, .stall, .take_jump, .jump_pc,
        .address_imem, .q_imem, .fd_pc, .fd_instr
    );

    decode_unit decode_i (
        .clock, .rst, .fd_pc, .fd_instr, .take_jump, .is_jal,
        .rd_a_reg, .rd_b_reg, .rd_a, .rd_b, .stall,
        .dx_pc, .dx_a, .dx_b, .dx_instr
    );

    reg_file reg_file_i (
        .clock, .rst,
        .we      (wb_en),
        .wr_reg  (wb_reg),
        .wr_data (wb_value),
        .rd_a_reg, .rd_b_reg, .rd_a, .rd_b
    );

    execute_unit execute_i (
        .clock, .rst, .dx_pc, .dx_a, .dx_b, .dx_instr,
        .wb_value, .wb_reg, .wb_en,
        .take_jump, .jump_pc, .is_jal,
        .xm_value, .xm_b, .xm_instr
    );

    memory_writeback mem_wb_i (
        .clock, .rst, .xm_value, .xm_b, .xm_instr,
        .address_dmem, .data, .wren, .q_dmem,
        .wb_en, .wb_reg, .wb_value
    );

endmodule

`default_nettype wire

//--- sim/processor_properties.sv
// --------------------------------------------------------------------------
// Assertions bound into the CPU core
// Reset state, register write port and PC hold on a stall
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module processor_properties import cpu_pkg::*; (
    input logic                      clock,
    input logic                      rst,
    input logic                      wren,
    input logic                      wb_en,
    input instr_t                    xm_instr,
    input logic                      stall,
    input logic                      take_jump,
    input logic [`WORD_BITS-1:0]     address_imem
);

    // No store right after a reset edge
    assert property (@(posedge clock) rst |=> !wren)
        else $error("wren high in the cycle after reset");

    // r0 destination in XM never reaches the register write port
    assert property (@(posedge clock) (xm_instr.i.rd == '0) |=> !wb_en)
        else $error("register write enabled for r0");

    // Load-use stall freezes the PC, a jump overrides it
    assert property (@(posedge clock) disable iff (rst)
                     (stall && !take_jump) |=> $stable(address_imem))
        else $error("instruction address moved during a stall");

endmodule

bind processor processor_properties props_i (
    .clock, .rst, .wren, .wb_en, .xm_instr, .stall, .take_jump, .address_imem
);

`default_nettype wire

//--- sim/processor_tb.sv
// --------------------------------------------------------------------------
// Testbench for the five-stage CPU core
// Builds small programs from a test table, runs them and checks every store
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module processor_tb import cpu_pkg::*; ;

    localparam int RESET_CYCLES = 16;
    localparam int PROG_WORDS   = 8;      // Longest program, rounded up
    localparam int DRAIN        = 8;      // Idle cycles after the last store
    localparam int WAIT_LIMIT   = (PROG_WORDS + DRAIN) * 2;

    // Test kinds
    localparam int K_ALU = 0, K_LDUSE = 1, K_BNE = 2, K_BLT = 3;
    localparam int K_J = 4, K_JAL = 5, K_STBYP = 6;

    typedef struct {
        string                 name;
        int                    kind;
        logic [4:0]            aluop;
        logic [`WORD_BITS-1:0] a, b;
        int                    n_st;          // Expected number of stores
        logic [`WORD_BITS-1:0] addr0, data0, addr1, data1;
    } test_t;

    logic                  clock = 1'b0;
    logic                  rst = 1'b1;
    logic [`WORD_BITS-1:0] address_imem, q_imem;
    logic [`WORD_BITS-1:0] address_dmem, data, q_dmem;
    logic                  wren;

    instr_t                imem [256];
    logic [`WORD_BITS-1:0] dmem [256];
    logic [`WORD_BITS-1:0] st_addr [$];    // Stores seen in this test
    logic [`WORD_BITS-1:0] st_data [$];
    test_t                 tests [$];
    int                    seed = 32'hf76f_6fe0;
    int                    errors = 0;
    int                    passed = 0;
    int                    failed = 0;
    int                    cycle_count = 0;
    int                    cycle_limit = 100000;

    processor processor_i (
        .clock, .rst, .address_imem, .q_imem,
        .address_dmem, .data, .wren, .q_dmem
    );

    always #2 clock = ~clock;              // 4 ns period

    // Memories, combinational reads
    assign q_imem = imem[address_imem[7:0]];
    assign q_dmem = dmem[address_dmem[7:0]];

    // Data memory fill during reset, then stores taken at the rising edge
    always @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < 256; i++)
                dmem[i] <= 32'h5a00_0000 ^ (i * 32'h0001_0003);
            st_addr.delete();
            st_data.delete();
        end else if (wren) begin
            dmem[address_dmem[7:0]] <= data;
            st_addr.push_back(address_dmem);
            st_data.push_back(data);
        end
    end

    // Watchdog
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Run stopped after %0d cycles without finishing", cycle_count);
            $display("sim failed");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // Encoders and reference model
    // ----------------------------------------------------------------------
    function automatic instr_t enc_r(input logic [4:0] rd, rs, rt, shamt, aluop);
        instr_t w;
        w = '0;
        w.r.opcode = `OPC_RTYPE;
        w.r.rd = rd;
        w.r.rs = rs;
        w.r.rt = rt;
        w.r.shamt = shamt;
        w.r.aluop = aluop;
        return w;
    endfunction

    function automatic instr_t enc_i(input logic [4:0] opc, rd, rs, input logic [16:0] imm);
        instr_t w;
        w = '0;
        w.i.opcode = opc;
        w.i.rd = rd;
        w.i.rs = rs;
        w.i.immediate = imm;
        return w;
    endfunction

    function automatic instr_t enc_j(input logic [4:0] opc, input logic [26:0] target);
        instr_t w;
        w = '0;
        w.j.opcode = opc;
        w.j.target = target;
        return w;
    endfunction

    function automatic logic [`WORD_BITS-1:0] sext17(input logic [16:0] v);
        return {{(`WORD_BITS-17){v[16]}}, v};
    endfunction

    // Random operand that fits the 17-bit immediate
    function automatic logic [`WORD_BITS-1:0] rand_imm();
        int r;
        r = $random(seed);
        return sext17(r[16:0]);
    endfunction

    // Shifts move a by the low five bits of b, which go into shamt
    function automatic logic [`WORD_BITS-1:0] model_alu(input logic [4:0] op,
                                                        input logic [`WORD_BITS-1:0] a, b);
        case (op)
            `ALU_ADD: return a + b;
            `ALU_SUB: return a - b;
            `ALU_AND: return a & b;
            `ALU_OR:  return a | b;
            `ALU_SLL: return a << b[4:0];
            default:  return $signed(a) >>> b[4:0];
        endcase
    endfunction

    // ----------------------------------------------------------------------
    // Test table
    // ----------------------------------------------------------------------
    task automatic add_test(input string name, input int kind, input logic [4:0] aluop,
                            input logic [`WORD_BITS-1:0] a, b);
        test_t t;
        logic  taken;
        t.name = name;
        t.kind = kind;
        t.aluop = aluop;
        t.a = a;
        t.b = b;
        t.addr1 = '0;
        t.data1 = '0;
        case (kind)
            K_ALU: begin
                t.n_st = 1;
                t.addr0 = 'h40;
                t.data0 = model_alu(aluop, a, b);
            end
            K_LDUSE: begin
                t.n_st = 2;
                t.addr0 = 'h20;
                t.data0 = a;
                t.addr1 = 'h41;
                t.data1 = a + a;
            end
            K_BNE, K_BLT: begin
                // bne skips on rd != rs, blt on rd < rs, with rd = r2 = b
                taken = (kind == K_BNE) ? (a != b) : ($signed(b) < $signed(a));
                t.n_st = taken ? 1 : 2;
                t.addr0 = taken ? 'h51 : 'h50;
                t.data0 = taken ? b : a;
                t.addr1 = 'h51;
                t.data1 = b;
            end
            K_J: begin
                t.n_st = 1;
                t.addr0 = 'h61;
                t.data0 = a;
            end
            K_JAL: begin
                t.n_st = 2;
                t.addr0 = 'h70;
                t.data0 = 2;
                t.addr1 = 'h71;
                t.data1 = a;
            end
            default: begin
                t.n_st = 1;
                t.addr0 = 'h30;
                t.data0 = a;
            end
        endcase
        tests.push_back(t);
    endtask

    task automatic build_table();
        logic [4:0]  ops [6];
        string       op_names [6];
        logic [`WORD_BITS-1:0] a, b;
        ops = '{`ALU_ADD, `ALU_SUB, `ALU_AND, `ALU_OR, `ALU_SLL, `ALU_SRA};
        op_names = '{"add", "sub", "and", "or", "sll", "sra"};
        for (int i = 0; i < 12; i++) begin
            a = rand_imm();
            b = rand_imm();
            add_test($sformatf("alu_%s_%0d", op_names[i % 6], i / 6), K_ALU, ops[i % 6], a, b);
        end
        for (int i = 0; i < 2; i++) begin
            add_test($sformatf("load_use_%0d", i), K_LDUSE, '0, rand_imm(), '0);
            add_test($sformatf("store_bypass_%0d", i), K_STBYP, '0, rand_imm(), '0);
        end
        a = rand_imm();
        add_test("bne_equal", K_BNE, '0, a, a);                      // Not taken
        add_test("bne_differ", K_BNE, '0, a, rand_imm());
        add_test("blt_equal", K_BLT, '0, a, a);
        add_test("blt_less", K_BLT, '0, 32'd100, 32'd5);             // Taken
        add_test("blt_greater", K_BLT, '0, 32'd5, 32'd100);
        add_test("jump", K_J, '0, rand_imm(), '0);
        add_test("jal_jr", K_JAL, '0, rand_imm(), '0);
    endtask

    // ----------------------------------------------------------------------
    // Program builder and run
    // ----------------------------------------------------------------------
    task automatic build_program(input test_t t);
        for (int i = 0; i < 256; i++)
            imem[i] = '0;                            // nop
        imem[0] = enc_i(`OPC_ADDI, 5'd1, 5'd0, t.a[16:0]);
        case (t.kind)
            K_ALU: begin
                imem[1] = enc_i(`OPC_ADDI, 5'd2, 5'd0, t.b[16:0]);
                imem[2] = enc_r(5'd3, 5'd1, 5'd2, t.b[4:0], t.aluop);
                imem[3] = enc_i(`OPC_SW, 5'd3, 5'd0, 17'h40);
                imem[4] = enc_j(`OPC_J, 27'd4);      // Halt loop
            end
            K_LDUSE: begin
                imem[1] = enc_i(`OPC_SW, 5'd1, 5'd0, 17'h20);
                imem[2] = enc_i(`OPC_LW, 5'd4, 5'd0, 17'h20);
                imem[3] = enc_r(5'd5, 5'd4, 5'd4, 5'd0, `ALU_ADD);
                imem[4] = enc_i(`OPC_SW, 5'd5, 5'd0, 17'h41);
                imem[5] = enc_j(`OPC_J, 27'd5);
            end
            K_BNE, K_BLT: begin
                imem[1] = enc_i(`OPC_ADDI, 5'd2, 5'd0, t.b[16:0]);
                imem[2] = enc_i((t.kind == K_BNE) ? `OPC_BNE : `OPC_BLT, 5'd2, 5'd1, 17'd1);
                imem[3] = enc_i(`OPC_SW, 5'd1, 5'd0, 17'h50);   // Marker
                imem[4] = enc_i(`OPC_SW, 5'd2, 5'd0, 17'h51);
                imem[5] = enc_j(`OPC_J, 27'd5);
            end
            K_J: begin
                imem[1] = enc_j(`OPC_J, 27'd3);
                imem[2] = enc_i(`OPC_SW, 5'd0, 5'd0, 17'h60);   // Skipped
                imem[3] = enc_i(`OPC_SW, 5'd1, 5'd0, 17'h61);
                imem[4] = enc_j(`OPC_J, 27'd4);
            end
            K_JAL: begin
                imem[1] = enc_j(`OPC_JAL, 27'd4);
                imem[2] = enc_i(`OPC_SW, 5'd1, 5'd0, 17'h71);   // After return
                imem[3] = enc_j(`OPC_J, 27'd3);
                imem[4] = enc_i(`OPC_SW, `LINK_REG, 5'd0, 17'h70);
                imem[5] = enc_i(`OPC_JR, `LINK_REG, 5'd0, 17'd0);
            end
            default: begin
                imem[1] = enc_i(`OPC_SW, 5'd1, 5'd0, 17'h30);
                imem[2] = enc_j(`OPC_J, 27'd2);
            end
        endcase
    endtask

    task automatic check_word(input string name, input string what,
                              input logic [`WORD_BITS-1:0] exp, act);
        if (act !== exp) begin
            $display("Mismatch %s %s: expected %h, actual %h", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, act);
        if (act != exp) begin
            $display("Mismatch %s store count: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic run_test(input test_t t);
        int waited;
        int errors_before;
        errors_before = errors;
        @(negedge clock);
        rst = 1'b1;
        build_program(t);
        repeat (RESET_CYCLES) @(negedge clock);
        rst = 1'b0;
        waited = 0;
        while (st_data.size() < t.n_st && waited < WAIT_LIMIT) begin
            @(negedge clock);
            waited++;
        end
        if (st_data.size() < t.n_st) begin
            $display("%s: expected stores did not appear within %0d cycles", t.name, waited);
        end
        repeat (DRAIN) @(negedge clock);
        check_count(t.name, t.n_st, st_data.size());
        if (st_data.size() > 0) begin
            check_word(t.name, "address 0", t.addr0, st_addr[0]);
            check_word(t.name, "data 0", t.data0, st_data[0]);
        end
        if (t.n_st > 1 && st_data.size() > 1) begin
            check_word(t.name, "address 1", t.addr1, st_addr[1]);
            check_word(t.name, "data 1", t.data1, st_data[1]);
        end
        if (errors == errors_before) begin
            $display("PASS %s", t.name);
            passed++;
        end else begin
            $display("FAIL %s", t.name);
            failed++;
        end
    endtask

    initial begin
        build_table();
        cycle_limit = tests.size() * (PROG_WORDS + RESET_CYCLES + DRAIN) * 2;
        foreach (tests[i])
            run_test(tests[i]);
        $display("%0d tests passed, %0d tests failed", passed, failed);
        if (failed == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+design
design/cpu_pkg.sv
design/alu.sv
design/reg_file.sv
design/fetch_unit.sv
design/decode_unit.sv
design/execute_unit.sv
design/memory_writeback.sv
design/processor.sv
sim/processor_properties.sv
sim/processor_tb.sv

//--- Makefile
# Verilator build and run for the pipelined CPU core

VERILATOR ?= verilator
TOP       ?= processor_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "sim passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
